//--- rtl/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;     // 2K x 8 array
    localparam int DATA_W = 8;
    localparam int DEV_W  = 4;

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] data_byte_t;

    // upper nibble of the control byte
    localparam logic [DEV_W-1:0] DEVICE_CODE = 4'b1010;

    // commands understood by the bit engine
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,   // also the repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,   // byte out, ninth bit released
        CMD_READ  = 2'd3    // byte in, ninth bit left as nack
    } bus_cmd_t;

endpackage

//--- rtl/i2c_bit_engine.sv
`timescale 1ns/1ns
module i2c_bit_engine
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::bus_cmd_t    cmd,
    input  logic                    cmd_valid,
    input  eeprom_pkg::data_byte_t  tx_byte,
    output eeprom_pkg::data_byte_t  rx_byte,
    output logic                    done,
    output logic                    scl,
    inout  wire                     sda
);
    import eeprom_pkg::*;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_START,
        ST_SHIFT,
        ST_STOP
    } eng_state_t;

    eng_state_t  state;
    logic [3:0]  cnt;       // cycle count for start/stop, bit count for shifts
    logic        phase;     // 0 raises scl, 1 lowers it
    logic        reading;
    logic        sda_low;
    data_byte_t  tx_sh;

    logic        accept;
    logic        last_cycle;

    // open drain, never driven high
    assign sda = sda_low ? 1'b0 : 1'bz;

    assign accept = (state == ST_IDLE) && cmd_valid;

    assign last_cycle = ((state == ST_START || state == ST_STOP) && cnt == 4'd3) ||
                        (state == ST_SHIFT && phase && cnt == 4'd8);

    assign done = last_cycle;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            cnt     <= 4'd0;
            phase   <= 1'b0;
            reading <= 1'b0;
            sda_low <= 1'b0;
            scl     <= 1'b1;        // bus idles high
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        cnt   <= 4'd0;
                        phase <= 1'b0;
                        case (cmd)
                            CMD_START:
                            begin
                                scl     <= 1'b1;    // release first for repeated start
                                sda_low <= 1'b0;
                                state   <= ST_START;
                            end
                            CMD_STOP:
                            begin
                                sda_low <= 1'b1;
                                state   <= ST_STOP;
                            end
                            CMD_WRITE:
                            begin
                                sda_low <= ~tx_byte[7]; // msb first
                                reading <= 1'b0;
                                state   <= ST_SHIFT;
                            end
                            default:
                            begin
                                sda_low <= 1'b0;
                                reading <= 1'b1;
                                state   <= ST_SHIFT;
                            end
                        endcase
                    end
                end
                ST_START:
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd0)
                        sda_low <= 1'b1;    // sda falls with scl high
                    if (cnt == 4'd2)
                        scl <= 1'b0;
                    if (last_cycle)
                        state <= ST_IDLE;
                end
                ST_STOP:
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd0)
                        scl <= 1'b1;
                    if (cnt == 4'd2)
                        sda_low <= 1'b0;    // sda rises with scl high
                    if (last_cycle)
                        state <= ST_IDLE;
                end
                default:
                begin
                    phase <= ~phase;
                    if (!phase)
                        scl <= 1'b1;
                    else
                    begin
                        scl <= 1'b0;
                        cnt <= cnt + 4'd1;
                        if (!reading)
                            sda_low <= ~tx_sh[6];   // next bit while scl low
                        if (last_cycle)
                            state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // shift registers, ones fill in so the ninth bit is released
    always_ff @(posedge CLK)
    begin
        if (accept)
            tx_sh <= tx_byte;
        else if (state == ST_SHIFT && phase)
            tx_sh <= {tx_sh[6:0], 1'b1};

        if (state == ST_SHIFT && phase && reading && cnt < 4'd8)
            rx_byte <= {rx_byte[6:0], sda};     // sampled while scl high
    end

endmodule

//--- rtl/eeprom_seq.sv
`timescale 1ns/1ns
module eeprom_seq
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::mem_addr_t   addr,
    input  eeprom_pkg::data_byte_t  wr_data,
    input  eeprom_pkg::data_byte_t  rx_byte,
    input  logic                    done,
    output eeprom_pkg::data_byte_t  rd_data,
    output logic                    ack,
    output eeprom_pkg::bus_cmd_t    cmd,
    output logic                    cmd_valid,
    output eeprom_pkg::data_byte_t  tx_byte
);
    import eeprom_pkg::*;

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_WR_START,
        S_CTRL_WR,
        S_ADDR_WR,
        S_DATA_WR,
        S_RD_START,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_ACK
    } seq_state_t;

    seq_state_t  state;
    seq_state_t  nxt_state;
    bus_cmd_t    nxt_cmd;
    data_byte_t  nxt_byte;
    logic        issue;

    logic        op_read;
    mem_addr_t   addr_q;
    data_byte_t  data_q;

    always_comb
    begin
        nxt_state = state;
        case (state)
            S_IDLE:
            begin
                if (wr || rd)
                    nxt_state = S_WR_START;     // random read begins with a dummy write
            end
            S_WR_START:
                if (done)
                    nxt_state = S_CTRL_WR;
            S_CTRL_WR:
                if (done)
                    nxt_state = S_ADDR_WR;
            S_ADDR_WR:
                if (done)
                    nxt_state = op_read ? S_RD_START : S_DATA_WR;
            S_DATA_WR:
                if (done)
                    nxt_state = S_STOP;
            S_RD_START:
                if (done)
                    nxt_state = S_CTRL_RD;
            S_CTRL_RD:
                if (done)
                    nxt_state = S_DATA_RD;
            S_DATA_RD:
                if (done)
                    nxt_state = S_STOP;
            S_STOP:
                if (done)
                    nxt_state = S_ACK;
            default:
                nxt_state = S_IDLE;
        endcase
    end

    // command for the state being entered
    always_comb
    begin
        nxt_cmd  = CMD_WRITE;
        nxt_byte = '1;
        case (nxt_state)
            S_WR_START,
            S_RD_START:
                nxt_cmd = CMD_START;
            S_CTRL_WR:
                nxt_byte = {DEVICE_CODE, addr_q[10:8], 1'b0};
            S_ADDR_WR:
                nxt_byte = addr_q[7:0];
            S_DATA_WR:
                nxt_byte = data_q;
            S_CTRL_RD:
                nxt_byte = {DEVICE_CODE, addr_q[10:8], 1'b1};
            S_DATA_RD:
                nxt_cmd = CMD_READ;
            default:
                nxt_cmd = CMD_STOP;
        endcase
    end

    assign issue = (nxt_state != state) && (nxt_state != S_IDLE) && (nxt_state != S_ACK);

    assign ack = (state == S_ACK);  // cycle after the stop completes

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
        end
        else
        begin
            state     <= nxt_state;
            cmd_valid <= issue;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && (wr || rd))
        begin
            op_read <= !wr;     // write wins on a tie
            addr_q  <= addr;
            data_q  <= wr_data;
        end

        if (issue)
        begin
            cmd     <= nxt_cmd;
            tx_byte <= nxt_byte;
        end

        if (state == S_DATA_RD && done)
            rd_data <= rx_byte;
    end

endmodule

//--- rtl/eeprom_wr.sv
`timescale 1ns/1ns
module eeprom_wr
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::mem_addr_t   addr,
    input  eeprom_pkg::data_byte_t  wr_data,
    output eeprom_pkg::data_byte_t  rd_data,
    output logic                    ack,
    output logic                    scl,
    inout  wire                     sda
);
    import eeprom_pkg::*;

    bus_cmd_t    cmd;
    logic        cmd_valid;
    data_byte_t  tx_byte;
    data_byte_t  rx_byte;
    logic        done;

    eeprom_seq i_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wr_data    (wr_data),
        .rx_byte    (rx_byte),
        .done       (done),
        .rd_data    (rd_data),
        .ack        (ack),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte)
    );

    i2c_bit_engine i_engine
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .rx_byte    (rx_byte),
        .done       (done),
        .scl        (scl),
        .sda        (sda)
    );

endmodule

//--- bench/eeprom_model.sv
`timescale 1ns/1ns
module eeprom_model
(
    input  logic  scl,
    inout  wire   sda
);
    import eeprom_pkg::*;

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_SEND
    } model_mode_t;

    data_byte_t   mem [0:2047];
    model_mode_t  mode = M_IDLE;
    model_mode_t  nxt_mode = M_IDLE;   // mode after the ninth bit
    mem_addr_t    ptr = '0;
    data_byte_t   sh = '0;
    logic [3:0]   bit_cnt = 4'd0;
    logic         drive_low = 1'b0;
    logic         scl_q = 1'b1;
    logic         sda_q = 1'b1;
    logic         scl_now;
    logic         sda_now;
    logic [11:0]  a;

    assign sda = drive_low ? 1'b0 : 1'bz;  // open drain

    task finish_byte();
        case (mode)
            M_CTRL:
            begin
                if (sh[7:4] == DEVICE_CODE)
                begin
                    ptr[10:8] = sh[3:1];
                    nxt_mode  = sh[0] ? M_SEND : M_ADDR;
                    drive_low = 1'b1;
                end
                else
                    nxt_mode = M_IDLE;    // not ours, stay off the bus
            end
            M_ADDR:
            begin
                ptr[7:0]  = sh;
                nxt_mode  = M_DATA;
                drive_low = 1'b1;
            end
            M_DATA:
            begin
                mem[ptr]  = sh;
                ptr       = ptr + 11'd1;
                nxt_mode  = M_DATA;
                drive_low = 1'b1;
            end
            default:
            begin
                drive_low = 1'b0;         // master acks a read byte
                ptr       = ptr + 11'd1;
                nxt_mode  = M_SEND;
            end
        endcase
    endtask

    task on_rise();
        if (bit_cnt < 4'd8)
        begin
            if (mode != M_SEND)
                sh = {sh[6:0], sda_now};
            bit_cnt = bit_cnt + 4'd1;
        end
        else if (bit_cnt == 4'd8)
        begin
            bit_cnt = 4'd9;
            if (mode == M_SEND && sda_now)
                nxt_mode = M_IDLE;        // nack ends the read
        end
    endtask

    task on_fall();
        if (bit_cnt == 4'd8)
            finish_byte();
        else if (bit_cnt == 4'd9)
        begin
            drive_low = 1'b0;
            bit_cnt   = 4'd0;
            mode      = nxt_mode;
            if (mode == M_SEND)
            begin
                sh        = mem[ptr];
                drive_low = !sh[7];
            end
        end
        else if (mode == M_SEND && bit_cnt != 4'd0)
        begin
            sh        = {sh[6:0], 1'b1};
            drive_low = !sh[7];
        end
    endtask

    initial
    begin
        for (a = 12'd0; a < 12'd2048; a = a + 12'd1)
            mem[a[10:0]] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};

        // lines settle for 1 ns so a data change on the scl edge is no start or stop
        forever
        begin
            @(scl or sda);
            #1;
            scl_now = scl;
            sda_now = sda;
            if (scl_q && scl_now && sda_q && !sda_now)
            begin
                mode      = M_CTRL;       // start or repeated start
                bit_cnt   = 4'd0;
                drive_low = 1'b0;
            end
            else if (scl_q && scl_now && !sda_q && sda_now)
            begin
                mode      = M_IDLE;       // stop
                bit_cnt   = 4'd0;
                drive_low = 1'b0;
            end
            else if (!scl_q && scl_now && mode != M_IDLE)
                on_rise();
            else if (scl_q && !scl_now && mode != M_IDLE)
                on_fall();
            scl_q = scl_now;
            sda_q = sda_now;
        end
    end

endmodule

//--- bench/tb_eeprom_wr.sv
`timescale 1ns/1ns
module tb_eeprom_wr;
    import eeprom_pkg::*;

    localparam int NUM_TXN   = 94;
    localparam int ACK_LIMIT = 150;

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    logic        wr = 1'b0;
    logic        rd = 1'b0;
    mem_addr_t   addr = '0;
    data_byte_t  wr_data = '0;
    data_byte_t  rd_data;
    logic        ack;
    logic        scl;
    tri1         sda;       // bus pull-up

    data_byte_t  ref_mem [0:2047];
    mem_addr_t   written_q [$];
    int          errors = 0;
    int          mon_errors = 0;
    int          checks = 0;
    int          txn_count = 0;
    int          ack_count = 0;
    logic        ack_q = 1'b0;
    logic        in_txn = 1'b0;

    eeprom_wr i_dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .ack      (ack),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model i_eeprom
    (
        .scl  (scl),
        .sda  (sda)
    );

    always #50 CLK = ~CLK;

    // ack width and idle scl, looked at mid-cycle
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            if (ack)
                ack_count++;
            assert (!(ack && ack_q))
            else
            begin
                $display("Error at %0t: ack high for more than one cycle", $time);
                mon_errors++;
            end
            assert (in_txn || scl)
            else
            begin
                $display("Error at %0t: scl low while no transaction runs", $time);
                mon_errors++;
            end
        end
        ack_q = ack;
    end

    initial
    begin
        repeat (NUM_TXN * ACK_LIMIT + 100) @(posedge CLK);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic strobe(input logic do_wr, input logic do_rd, input mem_addr_t a,
                          input data_byte_t d);
        @(posedge CLK);
        wr      <= do_wr;
        rd      <= do_rd;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_ack(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < ACK_LIMIT)
        begin
            @(negedge CLK);
            seen = ack;
            n++;
        end
        if (!seen)
        begin
            $display("DUT gave no ack within %0d cycles, at time %0t", ACK_LIMIT, $time);
            errors++;
        end
        @(posedge CLK);
        in_txn = 1'b0;
        txn_count++;
    endtask

    task automatic compare_byte(input mem_addr_t a, input data_byte_t got,
                                input data_byte_t exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("Error at %0t: address %03h read %02h, expected %02h",
                     $time, a, got, exp);
            errors++;
        end
    endtask

    task automatic write_byte(input mem_addr_t a, input data_byte_t d);
        logic seen;
        in_txn = 1'b1;
        strobe(1'b1, 1'b0, a, d);
        wait_ack(seen);
        ref_mem[a] = d;
        written_q.push_back(a);
    endtask

    task automatic read_check(input mem_addr_t a);
        logic seen;
        in_txn = 1'b1;
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_ack(seen);
        if (seen)
            compare_byte(a, rd_data, ref_mem[a]);
    endtask

    task automatic write_then_read();
        write_byte(11'h123, 8'h5A);
        read_check(11'h123);
    endtask

    // blocks 0, 1, 2 and 4 share the low byte and differ in one high bit each
    task automatic high_bits_independent();
        for (int k = 0; k < 4; k++)
            write_byte({3'((1 << k) >> 1), 8'h47}, 8'(k * 37 + 11));
        for (int k = 0; k < 4; k++)
            read_check({3'((1 << k) >> 1), 8'h47});
    endtask

    task automatic random_write_read();
        mem_addr_t a;
        for (int i = 0; i < 40; i++)
        begin
            a = mem_addr_t'($urandom_range(2047, 0));
            write_byte(a, data_byte_t'($urandom()));
        end
        for (int i = 0; i < 40; i++)
        begin
            a = written_q[$urandom_range(written_q.size() - 1, 0)];
            read_check(a);
        end
    endtask

    task automatic tie_write_wins();
        logic seen;
        in_txn = 1'b1;
        strobe(1'b1, 1'b1, 11'h5E1, 8'h96);
        wait_ack(seen);
        ref_mem[11'h5E1] = 8'h96;
        read_check(11'h5E1);
    endtask

    task automatic busy_strobe_ignored();
        int   acks_before;
        logic seen;
        acks_before = ack_count;
        in_txn = 1'b1;
        strobe(1'b1, 1'b0, 11'h2A5, 8'h3C);
        repeat (10) @(posedge CLK);
        strobe(1'b1, 1'b1, 11'h2A5, 8'hC3);    // sequencer busy here
        wait_ack(seen);
        ref_mem[11'h2A5] = 8'h3C;
        repeat (20) @(posedge CLK);
        checks++;
        assert (ack_count == acks_before + 1)
        else
        begin
            $display("Error at %0t: %0d acks for one write", $time, ack_count - acks_before);
            errors++;
        end
        read_check(11'h2A5);
    endtask

    initial
    begin
        void'($urandom(98234));
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4) @(posedge CLK);
        write_then_read();
        high_bits_independent();
        random_write_read();
        tie_write_wins();
        busy_strobe_ignored();
        repeat (10) @(posedge CLK);
        checks++;
        assert (ack_count == txn_count)
        else
        begin
            $display("Error at %0t: %0d acks for %0d transactions", $time, ack_count, txn_count);
            errors++;
        end
        $display("%0d checks, %0d errors", checks, errors + mon_errors);
        if (errors + mon_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- eeprom_wr.f
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_seq.sv
rtl/eeprom_wr.sv
bench/eeprom_model.sv
bench/tb_eeprom_wr.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Mdir obj_dir --top-module tb_eeprom_wr \
		-f eeprom_wr.f -o tb_eeprom_wr

run: compile
	./obj_dir/tb_eeprom_wr > sim.log 2>&1; cat sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
